// ==== fm_kon_settings.svh ====
`ifndef FM_KON_SETTINGS_SVH
`define FM_KON_SETTINGS_SVH

// Channel and operator geometry
`define FM_NUM_CH     6                           // Channels per chip
`define FM_NUM_OP     4                           // Operators per channel
`define FM_NUM_SLOT   (`FM_NUM_CH * `FM_NUM_OP)   // Slots in one round

// Host command path
`define FM_CMD_DEPTH  4                           // Command queue entries
`define FM_CREDITS    `FM_CMD_DEPTH               // Host credits after reset

// Composite sine mode
`define FM_CSM_CH     2                           // Channel keyed on timer A overflow

`endif

// ==== fm_slot_pkg.sv ====
`include "fm_kon_settings.svh"

package fm_slot_pkg;

    // Channel number, 0 to 5
    typedef logic [$clog2(`FM_NUM_CH)-1:0] ch_t;

    // Operator number, 0 to 3
    typedef logic [$clog2(`FM_NUM_OP)-1:0] op_t;

    // One key bit per operator, bit n is operator n
    typedef logic [`FM_NUM_OP-1:0] op_mask_t;

endpackage

// ==== fm_host_pkg.sv ====
package fm_host_pkg;

    // Host opcodes
    typedef enum logic [2:0] {
        CMD_KEYON     = 3'd0,   // Write key mask of one channel
        CMD_TMR_LOAD  = 3'd1,   // Load timer A reload and count
        CMD_TMR_START = 3'd2,   // Timer A runs
        CMD_TMR_STOP  = 3'd3,   // Timer A halts
        CMD_CLR_FLAG  = 3'd4,   // Clear sticky overflow flag
        CMD_CSM       = 3'd5    // CSM on or off, data bit 0
    } cmd_op_t;

    // One queued command
    typedef struct packed {
        cmd_op_t          op;     // What to do
        fm_slot_pkg::ch_t ch;     // Target channel for key-on
        logic [9:0]       data;   // Key mask, timer value or CSM enable
    } cmd_t;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,   // Waiting for a queued command
        ST_DISPATCH = 2'd1,   // Acting on the popped command
        ST_WAIT_KEY = 2'd2    // Key-on request held for the ring
    } ctrl_state_t;

endpackage

// ==== fm_kon_if.sv ====
`timescale 1ns/1ps

interface fm_kon_if;
    import fm_slot_pkg::*;

    // Key-on request, held until taken
    logic       kon_req;      // Pending channel write
    ch_t        kon_ch;       // Channel to write
    op_mask_t   kon_mask;     // Four key bits for that channel
    logic       kon_taken;    // Ring wrote the mask this cycle

    // Timer A control
    logic       tmr_load;     // One-cycle load strobe
    logic [9:0] tmr_value;    // Reload value
    logic       tmr_run;      // Count enable, level
    logic       clr_flag;     // One-cycle flag clear strobe
    logic       csm_en;       // CSM mode, level

    modport ctrl (
        output kon_req, kon_ch, kon_mask,
        input  kon_taken,
        output tmr_load, tmr_value, tmr_run, clr_flag, csm_en
    );

    modport ring (
        input  kon_req, kon_ch, kon_mask,
        output kon_taken,
        input  csm_en
    );

    modport timer (
        input  tmr_load, tmr_value, tmr_run, clr_flag, csm_en
    );

endinterface

// ==== fm_slot_counter.sv ====
`timescale 1ns/1ps
`include "fm_kon_settings.svh"

module fm_slot_counter (
    input  logic             clk,
    input  logic             rst,
    output fm_slot_pkg::ch_t cur_ch,
    output fm_slot_pkg::op_t cur_op,
    output logic             round_end
);
    import fm_slot_pkg::*;

    logic ch_wrap;   // Last channel of an operator group
    logic op_wrap;   // Last operator

    assign ch_wrap = (cur_ch == ch_t'(`FM_NUM_CH - 1));
    assign op_wrap = (cur_op == op_t'(`FM_NUM_OP - 1));

    // Channel is the inner index, operator the outer
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_ch <= '0;
            cur_op <= '0;
        end else if (ch_wrap) begin
            cur_ch <= '0;                        // Back to channel 0
            if (op_wrap) begin
                cur_op <= '0;                    // New round
            end else begin
                cur_op <= cur_op + 1'b1;         // Next operator group
            end
        end else begin
            cur_ch <= cur_ch + 1'b1;
        end
    end

    // Operator 3, channel 5 closes the round
    assign round_end = ch_wrap && op_wrap;

endmodule

// ==== fm_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "fm_kon_settings.svh"

module fm_cmd_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  fm_host_pkg::cmd_t cmd,
    output logic              cmd_credit,
    fm_kon_if.ctrl            kif
);
    import fm_host_pkg::*;

    localparam int PTR_W = $clog2(`FM_CMD_DEPTH);

    cmd_t             queue [`FM_CMD_DEPTH];   // Command storage
    logic [PTR_W-1:0] wr_ptr;                  // Next free entry
    logic [PTR_W-1:0] rd_ptr;                  // Oldest entry
    logic [PTR_W:0]   count;                   // Entries held
    ctrl_state_t      state;
    cmd_t             cur_cmd;                 // Command being dispatched
    logic             run_q;                   // Timer A run bit
    logic             csm_q;                   // CSM enable bit
    logic             pop;                     // Take oldest command

    // Idle controller pulls the next command
    assign pop = (state == ST_IDLE) && (count != '0);

    // Host never sends without a credit, so no full check
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            queue[wr_ptr] <= cmd;
        end
        if (pop) begin
            cur_cmd <= queue[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // Both or neither
            endcase
            cmd_credit <= pop;                     // One credit back per pop
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            run_q <= 1'b0;
            csm_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state <= ST_DISPATCH;
                    end
                end
                ST_DISPATCH: begin
                    state <= ST_IDLE;                  // Timer commands done here
                    case (cur_cmd.op)
                        CMD_KEYON:     state <= ST_WAIT_KEY;
                        CMD_TMR_START: run_q <= 1'b1;
                        CMD_TMR_STOP:  run_q <= 1'b0;
                        CMD_CSM:       csm_q <= cur_cmd.data[0];
                        default:       ;               // Load and clear are strobes
                    endcase
                end
                ST_WAIT_KEY: begin
                    if (kif.kon_taken) begin
                        state <= ST_IDLE;              // Ring wrote the mask
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Key-on request held stable from cur_cmd
    assign kif.kon_req   = (state == ST_WAIT_KEY);
    assign kif.kon_ch    = cur_cmd.ch;
    assign kif.kon_mask  = cur_cmd.data[3:0];

    // Timer strobes during dispatch
    assign kif.tmr_load  = (state == ST_DISPATCH) && (cur_cmd.op == CMD_TMR_LOAD);
    assign kif.clr_flag  = (state == ST_DISPATCH) && (cur_cmd.op == CMD_CLR_FLAG);
    assign kif.tmr_value = cur_cmd.data;
    assign kif.tmr_run   = run_q;
    assign kif.csm_en    = csm_q;

endmodule

// ==== fm_timer_a.sv ====
`timescale 1ns/1ps

module fm_timer_a (
    input  logic     clk,
    input  logic     rst,
    input  logic     round_end,
    fm_kon_if.timer  tif,
    output logic     overflow_a,
    output logic     flag_a,
    output logic     csm_fire
);

    logic [9:0] count;    // Rounds counted
    logic [9:0] reload;   // Value restored on overflow
    logic       step;     // Count advances this cycle
    logic       wrap;     // Overflow this cycle

    assign step = tif.tmr_run && round_end;
    assign wrap = step && (count == 10'h3ff);

    always_ff @(posedge clk) begin
        if (rst) begin
            count  <= '0;
            reload <= '0;
        end else if (tif.tmr_load) begin
            reload <= tif.tmr_value;               // Load sets both
            count  <= tif.tmr_value;
        end else if (step) begin
            if (wrap) begin
                count <= reload;                   // Restart from reload
            end else begin
                count <= count + 1'b1;             // One step per round
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            overflow_a <= 1'b0;
            flag_a     <= 1'b0;
            csm_fire   <= 1'b0;
        end else begin
            overflow_a <= wrap;                    // Single-cycle pulse
            csm_fire   <= wrap && tif.csm_en;      // Ring forces next round
            if (wrap) begin
                flag_a <= 1'b1;                    // Set wins over clear
            end else if (tif.clr_flag) begin
                flag_a <= 1'b0;
            end
        end
    end

endmodule

// ==== fm_keyon_ring.sv ====
`timescale 1ns/1ps
`include "fm_kon_settings.svh"

module fm_keyon_ring (
    input  logic             clk,
    input  logic             rst,
    input  fm_slot_pkg::ch_t cur_ch,
    input  fm_slot_pkg::op_t cur_op,
    input  logic             csm_fire,
    fm_kon_if.ring           rif,
    output fm_slot_pkg::ch_t slot_ch,
    output fm_slot_pkg::op_t slot_op,
    output logic             key_on
);
    import fm_slot_pkg::*;

    logic [`FM_NUM_SLOT-1:0] ring;         // Bit 0 is the current slot
    logic [`FM_NUM_SLOT-1:0] ring_nxt;
    logic                    key_upnow;    // Write the pending channel now
    logic                    last_slot;    // Final slot of the round
    logic                    csm_pend;     // Overflow seen, waiting for round start
    logic                    csm_active;   // Forcing round in progress
    logic                    csm_slot;     // Force this slot on

    // Write at operator 3 of the requested channel
    assign key_upnow = rif.kon_req && (rif.kon_ch == cur_ch)
                       && (cur_op == op_t'(`FM_NUM_OP - 1));
    assign rif.kon_taken = key_upnow;

    assign last_slot = (cur_ch == ch_t'(`FM_NUM_CH - 1)) && (cur_op == op_t'(`FM_NUM_OP - 1));

    // Rotate, then overlay the channel's four bits
    // Operator o of the channel sits 6*(3-o) stages behind the head slot
    always_comb begin
        ring_nxt = {ring[0], ring[`FM_NUM_SLOT-1:1]};
        if (key_upnow) begin
            for (int o = 0; o < `FM_NUM_OP; o++) begin
                ring_nxt[`FM_NUM_SLOT - 1 - `FM_NUM_CH * (`FM_NUM_OP - 1 - o)] = rif.kon_mask[o];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ring <= '0;                            // All keys off
        end else begin
            ring <= ring_nxt;
        end
    end

    // Overflow held until the round boundary, then one full round
    always_ff @(posedge clk) begin
        if (rst) begin
            csm_pend   <= 1'b0;
            csm_active <= 1'b0;
        end else begin
            if (last_slot) begin
                csm_active <= csm_pend;
                csm_pend   <= 1'b0;
            end
            if (csm_fire) begin
                csm_pend <= 1'b1;
            end
        end
    end

    assign csm_slot = rif.csm_en && csm_active && (cur_ch == ch_t'(`FM_CSM_CH));

    // Slot number and key bit leave together
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_ch <= '0;
            slot_op <= '0;
            key_on  <= 1'b0;
        end else begin
            slot_ch <= cur_ch;
            slot_op <= cur_op;
            key_on  <= ring[0] | csm_slot;         // Stored bit or CSM force
        end
    end

endmodule

// ==== fm_kon_top.sv ====
`timescale 1ns/1ps

module fm_kon_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  fm_host_pkg::cmd_op_t cmd_op,
    input  fm_slot_pkg::ch_t     cmd_ch,
    input  logic [9:0]           cmd_data,
    output logic                 cmd_credit,
    output fm_slot_pkg::ch_t     slot_ch,
    output fm_slot_pkg::op_t     slot_op,
    output logic                 key_on,
    output logic                 overflow_a,
    output logic                 flag_a
);
    import fm_slot_pkg::*;
    import fm_host_pkg::*;

    ch_t  cur_ch;       // Counter channel
    op_t  cur_op;       // Counter operator
    logic round_end;    // Last slot of round
    logic csm_fire;     // Timer overflow with CSM on
    cmd_t cmd_word;     // Host fields packed

    assign cmd_word = '{op: cmd_op, ch: cmd_ch, data: cmd_data};

    fm_kon_if kif ();

    fm_slot_counter u_counter (
        .clk       (clk),
        .rst       (rst),
        .cur_ch    (cur_ch),
        .cur_op    (cur_op),
        .round_end (round_end)
    );

    fm_cmd_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd_word),
        .cmd_credit (cmd_credit),
        .kif        (kif.ctrl)
    );

    fm_timer_a u_timer (
        .clk        (clk),
        .rst        (rst),
        .round_end  (round_end),
        .tif        (kif.timer),
        .overflow_a (overflow_a),
        .flag_a     (flag_a),
        .csm_fire   (csm_fire)
    );

    fm_keyon_ring u_ring (
        .clk      (clk),
        .rst      (rst),
        .cur_ch   (cur_ch),
        .cur_op   (cur_op),
        .csm_fire (csm_fire),
        .rif      (kif.ring),
        .slot_ch  (slot_ch),
        .slot_op  (slot_op),
        .key_on   (key_on)
    );

endmodule

// ==== fm_clk_gen.sv ====
`timescale 1ns/1ps

module fm_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;          // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);      // Five cycles in reset
        #1 rst = 1'b0;                  // Released with the stimulus delay
    end

endmodule

// ==== fm_kon_asserts.sv ====
`timescale 1ns/1ps

module fm_kon_asserts (
    input logic             clk,
    input logic             rst,
    input logic             cmd_valid,
    input logic             cmd_credit,
    input logic             overflow_a,
    input logic             key_on,
    input fm_slot_pkg::ch_t slot_ch,
    input fm_slot_pkg::op_t slot_op
);

    int outstanding;   // Commands sent but not yet credited back

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(cmd_valid) - int'(cmd_credit);
        end
    end

    // Credit only for a command already sent
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        cmd_credit |-> (outstanding > 0))
        else $error("credit returned with nothing outstanding");

    overflow_pulse: assert property (@(posedge clk) disable iff (rst)
        overflow_a |=> !overflow_a)
        else $error("overflow_a held longer than one cycle");

    // Operator steps only at channel wrap
    op_step: assert property (@(posedge clk) disable iff (rst)
        (slot_op != $past(slot_op)) |-> ($past(slot_ch) == 5 && slot_ch == 0))
        else $error("slot_op changed away from a channel wrap");

    key_after_reset: assert property (@(posedge clk) $fell(rst) |-> !key_on)
        else $error("key_on high right after reset");

endmodule

// ==== fm_kon_tb.sv ====
`timescale 1ns/1ps
`include "fm_kon_settings.svh"

module fm_kon_tb;
    import fm_slot_pkg::*;
    import fm_host_pkg::*;

    logic       clk, rst, cmd_valid, cmd_credit, key_on, overflow_a, flag_a;
    cmd_op_t    cmd_op;
    ch_t        cmd_ch, slot_ch, prev_ch, exp_ch;
    op_t        slot_op, prev_op, exp_op;
    logic [9:0] cmd_data;
    int         cycle, checks, errors, credits, ovf_count, last_ovf, period, forced;
    int         csm_changed, c, n, v;
    int         last_kon [`FM_NUM_CH];   // Cycle of latest key-on activity per channel
    int         pend_ch [$];             // Queued commands, channel or -1
    op_mask_t   mask [`FM_NUM_CH];       // Model key masks
    logic       csm_on, csm_p1, csm_p2, csm_act, flag_hold, no_ovf, prev_ok, exp_key;
    logic       rst_q;                   // Reset as seen by the last rising edge

    fm_clk_gen clk_gen_inst (.clk(clk), .rst(rst));

    fm_kon_top fm_kon_top_inst (.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_ch(cmd_ch), .cmd_data(cmd_data), .cmd_credit(cmd_credit), .slot_ch(slot_ch),
        .slot_op(slot_op), .key_on(key_on), .overflow_a(overflow_a), .flag_a(flag_a));

    bind fm_kon_top fm_kon_asserts asserts_inst (.clk(clk), .rst(rst), .cmd_valid(cmd_valid),
        .cmd_credit(cmd_credit), .overflow_a(overflow_a), .key_on(key_on),
        .slot_ch(slot_ch), .slot_op(slot_op));

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Sends when a credit is held, updates the model at send time
    task automatic send_cmd(input cmd_op_t op, input ch_t ch, input logic [9:0] data);
        while (credits == 0) idle(1);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_ch    = ch;
        cmd_data  = data;
        credits--;
        pend_ch.push_back((op == CMD_KEYON) ? int'(ch) : -1);
        case (op)
            CMD_KEYON: begin
                mask[ch]     = data[3:0];
                last_kon[ch] = cycle;
            end
            CMD_TMR_LOAD: begin
                period   = (1024 - int'(data)) * `FM_NUM_SLOT;   // Rounds to wrap, in cycles
                last_ovf = -1;                                   // First interval unknown
            end
            CMD_TMR_START: no_ovf = 1'b0;
            CMD_TMR_STOP:  no_ovf = 1'b1;
            CMD_CLR_FLAG:  flag_hold = 1'b0;
            CMD_CSM: begin
                csm_on      = data[0];
                csm_changed = cycle;
            end
            default: ;
        endcase
        idle(1);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_quiet();
        while (credits != `FM_CREDITS) idle(1);
    endtask

    task automatic wait_overflow(input int count);
        int target;
        target = ovf_count + count;
        while (ovf_count < target) idle(1);
    endtask

    always @(posedge clk) begin
        cycle++;
        rst_q = rst;
        if (cycle > 6000) begin
            $display("Timeout: run went past 6000 cycles");
            $display("Test failed");
            $finish;
        end
    end

    // Outputs sampled mid-cycle, once a rising edge has seen reset low
    // The first output slot after reset still holds the reset value
    always @(negedge clk) begin
        if (!rst_q) begin
            if (slot_ch == 0 && slot_op == 0) begin   // Output round boundary
                csm_act = csm_p2;
                csm_p2  = csm_p1;
                csm_p1  = 1'b0;
            end
            if (prev_ok) begin
                exp_ch = (prev_ch == 5) ? ch_t'(0) : prev_ch + 3'd1;
                exp_op = (prev_ch == 5) ? prev_op + 2'd1 : prev_op;
                check("slot_ch", 32'(slot_ch), 32'(exp_ch));
                check("slot_op", 32'(slot_op), 32'(exp_op));
            end
            prev_ch = slot_ch;
            prev_op = slot_op;
            prev_ok = 1'b1;
            if (cycle - last_kon[slot_ch] > 120
                && (slot_ch != `FM_CSM_CH || cycle - csm_changed > 50)) begin
                exp_key = mask[slot_ch][slot_op];
                if (slot_ch == `FM_CSM_CH && csm_on && csm_act) begin
                    exp_key = 1'b1;   // CSM forced round
                    forced++;
                end
                check("key_on", 32'(key_on), 32'(exp_key));
            end
            if (overflow_a) begin
                ovf_count++;
                if (no_ovf) begin
                    errors++;
                    $display("Timer A overflowed although it was stopped");
                end
                if (last_ovf >= 0) check("overflow_a period", cycle - last_ovf, period);
                last_ovf  = cycle;
                flag_hold = 1'b1;
                if (csm_on) csm_p1 = 1'b1;   // Forced round follows the next one
            end
            if (flag_hold) check("flag_a", 32'(flag_a), 32'd1);
            if (cmd_credit) begin
                credits++;
                if (pend_ch.size() == 0) begin
                    errors++;
                    $display("A credit came back with no command outstanding");
                end else begin
                    c = pend_ch.pop_front();
                    if (c >= 0) last_kon[c] = cycle;   // Ring write still ahead
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h47c7));
        cmd_valid = 1'b0;
        cmd_op    = CMD_KEYON;
        cmd_ch    = '0;
        cmd_data  = '0;
        rst_q     = 1'b1;
        credits   = `FM_CREDITS;
        {cycle, checks, errors, ovf_count, forced, period} = '0;
        last_ovf    = -1;
        csm_changed = -1000;
        {csm_on, csm_p1, csm_p2, csm_act, flag_hold, no_ovf, prev_ok} = '0;
        for (int i = 0; i < `FM_NUM_CH; i++) begin
            mask[i]     = '0;
            last_kon[i] = -1000;
        end
        @(negedge rst);
        idle(1);
        repeat (6) begin                           // Random key-on bursts
            n = 1 + $urandom % 6;
            repeat (n) send_cmd(CMD_KEYON, ch_t'($urandom % 6), 10'($urandom % 16));
            idle($urandom % 20);
        end
        send_cmd(CMD_KEYON, ch_t'(`FM_CSM_CH), 10'h0);   // Channel 2 off, CSM shows clearly
        idle(130);
        v = 1016 + $urandom % 7;                   // Timer A, flag and stop
        send_cmd(CMD_TMR_LOAD, '0, 10'(v));
        send_cmd(CMD_TMR_START, '0, 10'h0);
        wait_overflow(4);
        send_cmd(CMD_CLR_FLAG, '0, 10'h0);
        wait_quiet();
        idle(3);
        check("flag_a after clear", 32'(flag_a), 32'd0);
        wait_overflow(1);
        send_cmd(CMD_TMR_STOP, '0, 10'h0);
        idle(400);
        send_cmd(CMD_CSM, '0, 10'h1);              // CSM on, then restart the timer
        idle(60);
        v = 1016 + $urandom % 7;
        send_cmd(CMD_TMR_LOAD, '0, 10'(v));
        send_cmd(CMD_TMR_START, '0, 10'h0);
        wait_overflow(3);
        idle(60);
        send_cmd(CMD_CSM, '0, 10'h0);              // Back to the stored mask
        wait_overflow(2);
        idle(60);
        send_cmd(CMD_TMR_STOP, '0, 10'h0);
        wait_quiet();
        idle(10);
        check("credits", 32'(credits), 32'(`FM_CREDITS));
        check("forced slots seen", 32'(forced >= 12), 32'd1);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== fm_kon.f ====
+incdir+.
fm_slot_pkg.sv
fm_host_pkg.sv
fm_kon_if.sv
fm_slot_counter.sv
fm_cmd_ctrl.sv
fm_timer_a.sv
fm_keyon_ring.sv
fm_kon_top.sv
fm_clk_gen.sv
fm_kon_asserts.sv
fm_kon_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fm_kon testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fm_kon.f --top-module fm_kon_tb -Mdir obj_dir

if ! ./obj_dir/Vfm_kon_tb > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
